// ==== source/clock_config.svh ====
`ifndef CLOCK_CONFIG_SVH
`define CLOCK_CONFIG_SVH

// Diagnostic bus word, six bits like the old readback field
`define DIAG_DATA_W 6

// Wishbone address width, also the function code width
`define DIAG_ADR_W 4

// Burst strobe counter
`define BURST_W 8

// Rate select, tick every 2**rate cycles
`define RATE_W 2

// Rate after reset, tick on every cycle
`define RESET_RATE 0

`endif

// ==== source/clockPkg.sv ====
`default_nettype none

`include "clock_config.svh"

package clockPkg;

  // Write functions, decoded from the Wishbone address
  typedef enum logic [`DIAG_ADR_W-1:0] {
    opStop        = 4'd0,
    opStart       = 4'd1,
    opSingleStep  = 4'd2,
    opBurst       = 4'd5,
    opClrReset    = 4'd6,
    opSetReset    = 4'd7,
    opLoadBurstLo = 4'd8,
    opLoadBurstHi = 4'd9,
    opLoadRate    = 4'd10,
    opLoadDisable = 4'd11
  } diagOpT;

  // Run control states
  typedef enum logic [1:0] {
    stStopped,
    stRunning,
    stBurst,
    stStep
  } runStateT;

  // One-cycle command pulses plus the write data they carry
  typedef struct packed {
    logic start;
    logic stop;
    logic step;
    logic burst;
    logic loadLo;
    logic loadHi;
    logic loadRate;
    logic loadDisable;
    logic [`DIAG_DATA_W-1:0] data;
  } diagCmdT;

  // One bit per clock domain
  typedef struct packed {
    logic crm;
    logic edp;
    logic ctl;
  } clockEnT;

  // Everything the host can read back
  typedef struct packed {
    runStateT runState;
    logic [`BURST_W-1:0] count;
    logic burstZero;
    logic [`RATE_W-1:0] rate;
    logic [1:0] sourceSel;
    clockEnT disables;
    logic cpuReset;
  } statusT;

endpackage

`default_nettype wire

// ==== source/diagBusPort.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "clock_config.svh"

module diagBusPort import clockPkg::*; (
  input  wire logic MAIN_SOURCE,
  input  wire logic CLK,
  input  wire logic cyc,
  input  wire logic stb,
  input  wire logic we,
  input  wire logic [`DIAG_ADR_W-1:0] adr,
  input  wire logic [`DIAG_DATA_W-1:0] datIn,
  output logic [`DIAG_DATA_W-1:0] datOut,
  output logic ack,
  input  statusT status,
  output diagCmdT cmd,
  output logic cpuReset
);

  diagOpT op;
  logic acked;
  logic request;
  logic writeCycle;
  logic setReset;
  logic clrReset;
  logic [`DIAG_DATA_W-1:0] readWord;

  assign op = diagOpT'(adr);

  // New request, not yet answered
  assign request = cyc & stb & ~ack & ~acked;

  // Write commands fire only in the ack cycle
  assign writeCycle = ack & cyc & stb & we;

  // Single-cycle ack, then stay quiet until stb drops
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      ack <= 1'b0;
      acked <= 1'b0;
    end else begin
      ack <= request;
      if (!(cyc && stb))
        acked <= 1'b0;
      else if (ack)
        acked <= 1'b1;
    end
  end

  // Function decode into pulses
  always_comb begin
    cmd = '0;
    cmd.data = datIn;
    setReset = 1'b0;
    clrReset = 1'b0;
    if (writeCycle) begin
      case (op)
        opStop:        cmd.stop = 1'b1;
        opStart:       cmd.start = 1'b1;
        opSingleStep:  cmd.step = 1'b1;
        opBurst:       cmd.burst = 1'b1;
        opClrReset:    clrReset = 1'b1;
        opSetReset:    setReset = 1'b1;
        opLoadBurstLo: cmd.loadLo = 1'b1;
        opLoadBurstHi: cmd.loadHi = 1'b1;
        opLoadRate:    cmd.loadRate = 1'b1;
        opLoadDisable: cmd.loadDisable = 1'b1;
        // Unused codes do nothing
        default: ;
      endcase
    end
  end

  // CPU reset flop, set on power-up
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK)
      cpuReset <= 1'b1;
    else if (setReset)
      cpuReset <= 1'b1;
    else if (clrReset)
      cpuReset <= 1'b0;
  end

  // Status word select
  // Disable bits sit on their own word since rate and source fill address 3
  always_comb begin
    case (adr)
      4'd0: readWord = {2'b00, status.runState, status.burstZero, status.cpuReset};
      4'd1: readWord = {2'b00, status.count[3:0]};
      4'd2: readWord = {2'b00, status.count[7:4]};
      4'd3: readWord = {2'b00, status.sourceSel, status.rate};
      4'd4: readWord = {3'b000, status.disables.ctl, status.disables.edp,
                        status.disables.crm};
      default: readWord = '0;
    endcase
  end

  // Read data valid during ack
  always_ff @(posedge MAIN_SOURCE) begin
    if (request && !we)
      datOut <= readWord;
  end

endmodule

`default_nettype wire

// ==== source/runControl.sv ====
`timescale 1ns/1ns
`default_nettype none

module runControl import clockPkg::*; (
  input  wire logic MAIN_SOURCE,
  input  wire logic CLK,
  input  diagCmdT cmd,
  input  wire logic tick,
  input  wire logic burstZero,
  output logic strobe,
  output logic decrement,
  output runStateT runState
);

  runStateT nextState;
  logic burstTick;

  // Burst tick only while strobes remain
  assign burstTick = (runState == stBurst) && tick && !burstZero;

  // Stop wins over a tick in the same cycle
  always_comb begin
    strobe = 1'b0;
    if (!cmd.stop) begin
      case (runState)
        stRunning: strobe = tick;
        stStep:    strobe = tick;
        stBurst:   strobe = burstTick;
        default:   strobe = 1'b0;
      endcase
    end
  end

  assign decrement = burstTick && !cmd.stop;

  always_comb begin
    nextState = runState;
    if (cmd.stop)
      nextState = stStopped;
    else if (cmd.start)
      nextState = stRunning;
    else if (cmd.step)
      nextState = stStep;
    else if (cmd.burst)
      // Empty burst goes nowhere
      nextState = burstZero ? stStopped : stBurst;
    else begin
      case (runState)
        // One strobe then done
        stStep:  if (tick) nextState = stStopped;
        // Count ran out
        stBurst: if (burstZero) nextState = stStopped;
        default: nextState = runState;
      endcase
    end
  end

  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK)
      runState <= stStopped;
    else
      runState <= nextState;
  end

endmodule

`default_nettype wire

// ==== source/burstCounter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "clock_config.svh"

module burstCounter import clockPkg::*; (
  input  wire logic MAIN_SOURCE,
  input  wire logic CLK,
  input  diagCmdT cmd,
  input  wire logic decrement,
  output logic [`BURST_W-1:0] count,
  output logic burstZero
);

  assign burstZero = (count == '0);

  // Nibble loads from the host, countdown from run control
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      count <= '0;
    end else if (cmd.loadLo) begin
      count[3:0] <= cmd.data[3:0];
    end else if (cmd.loadHi) begin
      count[7:4] <= cmd.data[3:0];
    end else if (decrement) begin
      // Run control only asks while strobes remain
      count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== source/rateDivider.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "clock_config.svh"

module rateDivider import clockPkg::*; (
  input  wire logic MAIN_SOURCE,
  input  wire logic CLK,
  input  diagCmdT cmd,
  output logic tick,
  output logic [`RATE_W-1:0] rate
);

  logic [2:0] phase;
  logic [2:0] phaseMask;

  // Low phase bits that must be zero for a tick
  always_comb begin
    case (rate)
      2'd0:    phaseMask = 3'b000;
      2'd1:    phaseMask = 3'b001;
      2'd2:    phaseMask = 3'b011;
      default: phaseMask = 3'b111;
    endcase
  end

  assign tick = ((phase & phaseMask) == 3'b000);

  // Rate load also restarts the phase
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      rate <= `RATE_W'(`RESET_RATE);
      phase <= 3'd0;
    end else if (cmd.loadRate) begin
      rate <= cmd.data[1:0];
      phase <= 3'd0;
    end else begin
      phase <= phase + 3'd1;
    end
  end

endmodule

`default_nettype wire

// ==== source/modeRegisters.sv ====
`timescale 1ns/1ns
`default_nettype none

module modeRegisters import clockPkg::*; (
  input  wire logic MAIN_SOURCE,
  input  wire logic CLK,
  input  diagCmdT cmd,
  input  wire logic strobe,
  output logic [1:0] sourceSel,
  output clockEnT disables,
  output clockEnT clockEn
);

  // Source select shares the rate word, bits 3:2
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      sourceSel <= 2'b00;
    end else if (cmd.loadRate) begin
      sourceSel <= cmd.data[3:2];
    end
  end

  // Bit 0 crm, bit 1 edp, bit 2 ctl
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      disables <= '0;
    end else if (cmd.loadDisable) begin
      disables.crm <= cmd.data[0];
      disables.edp <= cmd.data[1];
      disables.ctl <= cmd.data[2];
    end
  end

  // Domain enables, one cycle behind strobe
  always_ff @(posedge MAIN_SOURCE or posedge CLK) begin
    if (CLK) begin
      clockEn <= '0;
    end else begin
      clockEn.crm <= strobe & ~disables.crm;
      clockEn.edp <= strobe & ~disables.edp;
      clockEn.ctl <= strobe & ~disables.ctl;
    end
  end

endmodule

`default_nettype wire

// ==== source/clockBoard.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "clock_config.svh"

module clockBoard import clockPkg::*; (
  input  wire logic MAIN_SOURCE,
  input  wire logic CLK,
  input  wire logic cyc,
  input  wire logic stb,
  input  wire logic we,
  input  wire logic [`DIAG_ADR_W-1:0] adr,
  input  wire logic [`DIAG_DATA_W-1:0] datIn,
  output logic [`DIAG_DATA_W-1:0] datOut,
  output logic ack,
  output clockEnT clockEn,
  output logic cpuReset
);

  diagCmdT cmd;
  statusT status;
  runStateT runState;
  logic tick;
  logic strobe;
  logic decrement;
  logic burstZero;
  logic [`BURST_W-1:0] count;
  logic [`RATE_W-1:0] rate;
  logic [1:0] sourceSel;
  clockEnT disables;

  // Readback bundle for the host
  assign status = '{runState: runState, count: count, burstZero: burstZero,
                    rate: rate, sourceSel: sourceSel, disables: disables,
                    cpuReset: cpuReset};

  diagBusPort diagBusPort0 (.MAIN_SOURCE, .CLK, .cyc, .stb, .we, .adr, .datIn,
                            .datOut, .ack, .status, .cmd, .cpuReset);

  runControl runControl0 (.MAIN_SOURCE, .CLK, .cmd, .tick, .burstZero, .strobe,
                          .decrement, .runState);

  rateDivider rateDivider0 (.MAIN_SOURCE, .CLK, .cmd, .tick, .rate);

  burstCounter burstCounter0 (.MAIN_SOURCE, .CLK, .cmd, .decrement, .count, .burstZero);

  modeRegisters modeRegisters0 (.MAIN_SOURCE, .CLK, .cmd, .strobe, .sourceSel,
                                .disables, .clockEn);

endmodule

`default_nettype wire

// ==== tests/clockBoard_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockBoardChk import clockPkg::*; (
  input wire logic MAIN_SOURCE,
  input wire logic CLK,
  input wire logic cyc,
  input wire logic stb,
  input wire logic ack,
  input wire logic [2:0] clockEn,
  input wire logic [2:0] disables,
  input wire logic [1:0] runState
);

  // Ack is a single-cycle pulse
  ackPulse: assert property (@(posedge MAIN_SOURCE) disable iff (CLK) ack |=> !ack)
    else $error("ack high for two cycles in a row");

  // Ack only answers a request
  ackCause: assert property (@(posedge MAIN_SOURCE) disable iff (CLK)
    ack |-> $past(cyc && stb))
    else $error("ack without a prior cyc and stb");

  // A disabled domain never sees an enable
  maskedDomain: assert property (@(posedge MAIN_SOURCE) disable iff (CLK)
    (clockEn & disables) == 3'b000)
    else $error("clockEn high on a disabled domain");

  // No enables once stopped for more than a cycle
  stoppedQuiet: assert property (@(posedge MAIN_SOURCE) disable iff (CLK)
    (runState == stStopped && $past(runState) == stStopped) |-> clockEn == 3'b000)
    else $error("clockEn active while stopped");

endmodule

bind clockBoard clockBoardChk chk0 (
  .MAIN_SOURCE(MAIN_SOURCE),
  .CLK(CLK),
  .cyc(cyc),
  .stb(stb),
  .ack(ack),
  .clockEn(clockEn),
  .disables(disables),
  .runState(runState)
);

`default_nettype wire

// ==== tests/clockBoardTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "clock_config.svh"

module clockBoardTb import clockPkg::*; ();

  localparam int ClkHalf = 50;
  localparam int ResetCycles = 10;
  localparam int RowBudget = 64;
  localparam int AckTimeout = 16;
  localparam int StopPolls = 200;
  // Run window for start/stop, a multiple of every tick period
  localparam int RunWindow = 32;

  typedef enum {rowWrite, rowRead, rowIdle, rowMark, rowCheck, rowWaitStop} rowKindT;

  // One table entry
  typedef struct {
    rowKindT kind;
    logic [`DIAG_ADR_W-1:0] adr;
    logic [`DIAG_DATA_W-1:0] data;
    logic [`DIAG_DATA_W-1:0] expRead;
    int cycles;
    int expStrobes;
    int slack;
    // Bit 0 crm, bit 1 edp, bit 2 ctl
    logic [2:0] enMask;
  } rowT;

  logic MAIN_SOURCE;
  logic CLK;
  logic cyc;
  logic stb;
  logic we;
  logic [`DIAG_ADR_W-1:0] adr;
  logic [`DIAG_DATA_W-1:0] datIn;
  logic [`DIAG_DATA_W-1:0] datOut;
  logic ack;
  clockEnT clockEn;
  logic cpuReset;

  rowT rows[$];
  logic tableReady = 1'b0;
  logic runPassed = 1'b0;
  logic failShown = 1'b0;
  logic watchdogFired = 1'b0;

  // Strobe scoreboard, running totals plus a snapshot per test
  int crmCount = 0;
  int edpCount = 0;
  int ctlCount = 0;
  int crmBase = 0;
  int edpBase = 0;
  int ctlBase = 0;

  clockBoard dut0 (
    .MAIN_SOURCE, .CLK, .cyc, .stb, .we, .adr, .datIn, .datOut, .ack, .clockEn, .cpuReset
  );

  initial begin
    MAIN_SOURCE = 1'b0;
    forever #ClkHalf MAIN_SOURCE = ~MAIN_SOURCE;
  end

  // Enables are stable by the falling edge
  always @(negedge MAIN_SOURCE) begin
    if (clockEn.crm)
      crmCount++;
    if (clockEn.edp)
      edpCount++;
    if (clockEn.ctl)
      ctlCount++;
  end

  task automatic abortRun();
    failShown = 1'b1;
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic addRow(input rowKindT kind, input logic [`DIAG_ADR_W-1:0] a,
                        input logic [`DIAG_DATA_W-1:0] d, input logic [`DIAG_DATA_W-1:0] e,
                        input int n, input int strobes, input int slack, input logic [2:0] m);
    rowT r;
    r.kind = kind;
    r.adr = a;
    r.data = d;
    r.expRead = e;
    r.cycles = n;
    r.expStrobes = strobes;
    r.slack = slack;
    r.enMask = m;
    rows.push_back(r);
  endtask

  task automatic addWrite(input logic [`DIAG_ADR_W-1:0] a, input logic [`DIAG_DATA_W-1:0] d);
    addRow(rowWrite, a, d, '0, 0, 0, 0, '0);
  endtask

  task automatic addRead(input logic [`DIAG_ADR_W-1:0] a, input logic [`DIAG_DATA_W-1:0] e);
    addRow(rowRead, a, '0, e, 0, 0, 0, '0);
  endtask

  task automatic addCheck(input int strobes, input int slack, input logic [2:0] m);
    addRow(rowCheck, '0, '0, '0, 0, strobes, slack, m);
  endtask

  // Stimulus table, random values drawn after seeding
  task automatic buildTable();
    logic [7:0] loadCount;
    logic [1:0] rate;
    logic [1:0] src;
    logic [7:0] burstN;
    logic [7:0] burstM;
    logic [2:0] dis;
    loadCount = 8'($urandom);
    rate = 2'($urandom_range(3, 0));
    src = 2'($urandom);
    burstN = 8'($urandom_range(24, 1));
    burstM = 8'($urandom_range(24, 1));
    dis = 3'($urandom);
    // Reset state: stopped, count zero, cpuReset high, no strobes
    addRead(4'd0, 6'b000011);
    addRow(rowIdle, '0, '0, '0, 8, 0, 0, '0);
    addCheck(0, 0, 3'b111);
    // cpuReset pin follows clear and set
    addWrite(opClrReset, '0);
    addRead(4'd0, 6'b000010);
    addWrite(opSetReset, '0);
    addRead(4'd0, 6'b000011);
    // Count nibbles and rate word read back
    addWrite(opLoadBurstLo, {2'b00, loadCount[3:0]});
    addWrite(opLoadBurstHi, {2'b00, loadCount[7:4]});
    addWrite(opLoadRate, {2'b00, src, rate});
    addRead(4'd1, {2'b00, loadCount[3:0]});
    addRead(4'd2, {2'b00, loadCount[7:4]});
    addRead(4'd3, {2'b00, src, rate});
    // Burst of N on all domains
    addRow(rowMark, '0, '0, '0, 0, 0, 0, '0);
    addWrite(opLoadBurstLo, {2'b00, burstN[3:0]});
    addWrite(opLoadBurstHi, {2'b00, burstN[7:4]});
    addWrite(opBurst, '0);
    addRow(rowWaitStop, '0, '0, '0, 0, 0, 0, '0);
    addCheck(int'(burstN), 0, 3'b111);
    addRead(4'd1, '0);
    addRead(4'd2, '0);
    addRead(4'd0, 6'b000011);
    // Burst with an empty count does nothing
    addRow(rowMark, '0, '0, '0, 0, 0, 0, '0);
    addWrite(opBurst, '0);
    addRow(rowIdle, '0, '0, '0, 8, 0, 0, '0);
    addCheck(0, 0, 3'b111);
    // Single step
    addRow(rowMark, '0, '0, '0, 0, 0, 0, '0);
    addWrite(opSingleStep, '0);
    addRow(rowWaitStop, '0, '0, '0, 0, 0, 0, '0);
    addCheck(1, 0, 3'b111);
    // Start, then stop after the window; bus overhead makes up two cycles
    addRow(rowMark, '0, '0, '0, 0, 0, 0, '0);
    addWrite(opStart, '0);
    addRow(rowIdle, '0, '0, '0, RunWindow - 2, 0, 0, '0);
    addWrite(opStop, '0);
    addCheck(RunWindow >> rate, 1, 3'b111);
    addRead(4'd0, 6'b000011);
    // Masked burst
    addWrite(opLoadDisable, {3'b000, dis});
    addRead(4'd4, {3'b000, dis});
    addRow(rowMark, '0, '0, '0, 0, 0, 0, '0);
    addWrite(opLoadBurstLo, {2'b00, burstM[3:0]});
    addWrite(opLoadBurstHi, {2'b00, burstM[7:4]});
    addWrite(opBurst, '0);
    addRow(rowWaitStop, '0, '0, '0, 0, 0, 0, '0);
    addCheck(int'(burstM), 0, ~dis);
    addWrite(opLoadDisable, '0);
    addRead(4'd4, '0);
  endtask

  // Wishbone classic access, held until ack
  task automatic busAccess(input logic write, input logic [`DIAG_ADR_W-1:0] a,
                           input logic [`DIAG_DATA_W-1:0] d,
                           output logic [`DIAG_DATA_W-1:0] rd);
    int waited;
    waited = 0;
    @(posedge MAIN_SOURCE);
    cyc <= 1'b1;
    stb <= 1'b1;
    we <= write;
    adr <= a;
    datIn <= d;
    @(negedge MAIN_SOURCE);
    while (!ack && waited < AckTimeout) begin
      @(negedge MAIN_SOURCE);
      waited++;
    end
    assert (ack) else begin
      $display("The DUT never acknowledged the bus access at address %0d", a);
      abortRun();
    end
    rd = datOut;
    // Drop the request in the cycle after ack
    @(posedge MAIN_SOURCE);
    cyc <= 1'b0;
    stb <= 1'b0;
    we <= 1'b0;
  endtask

  // Poll the run state until stopped
  task automatic waitStopped();
    logic [`DIAG_DATA_W-1:0] rd;
    int polls;
    polls = 0;
    rd = '1;
    while (rd[3:2] != stStopped && polls < StopPolls) begin
      busAccess(1'b0, '0, '0, rd);
      polls++;
    end
    assert (rd[3:2] == stStopped) else begin
      $display("Run control did not return to stopped after %0d polls", polls);
      abortRun();
    end
  endtask

  task automatic checkStrobes(input string name, input int got, input int expected,
                              input int slack);
    assert (got >= expected - slack && got <= expected + slack) else begin
      $display("ERROR t=%0t %s expected %0d got %0d", $time, name, expected, got);
      abortRun();
    end
  endtask

  task automatic applyRow(input rowT r);
    logic [`DIAG_DATA_W-1:0] rd;
    case (r.kind)
      rowWrite: busAccess(1'b1, r.adr, r.data, rd);
      rowRead: begin
        busAccess(1'b0, r.adr, '0, rd);
        assert (rd == r.expRead) else begin
          $display("ERROR t=%0t datOut at adr %0d expected %h got %h", $time, r.adr,
                   r.expRead, rd);
          abortRun();
        end
        // Status word 0 also mirrors the pin
        if (r.adr == '0) begin
          assert (cpuReset == r.expRead[0]) else begin
            $display("ERROR t=%0t cpuReset expected %b got %b", $time, r.expRead[0], cpuReset);
            abortRun();
          end
        end
      end
      rowIdle: repeat (r.cycles) @(posedge MAIN_SOURCE);
      rowMark: begin
        crmBase = crmCount;
        edpBase = edpCount;
        ctlBase = ctlCount;
      end
      rowCheck: begin
        checkStrobes("clockEn.crm", crmCount - crmBase, r.enMask[0] ? r.expStrobes : 0, r.slack);
        checkStrobes("clockEn.edp", edpCount - edpBase, r.enMask[1] ? r.expStrobes : 0, r.slack);
        checkStrobes("clockEn.ctl", ctlCount - ctlBase, r.enMask[2] ? r.expStrobes : 0, r.slack);
      end
      default: waitStopped();
    endcase
  endtask

  initial begin
    void'($urandom(32'h895));
    CLK <= 1'b1;
    cyc <= 1'b0;
    stb <= 1'b0;
    we <= 1'b0;
    adr <= '0;
    datIn <= '0;
    buildTable();
    tableReady = 1'b1;
    repeat (ResetCycles) @(posedge MAIN_SOURCE);
    CLK <= 1'b0;
    foreach (rows[i])
      applyRow(rows[i]);
    runPassed = 1'b1;
    $display("Simulation completed successfully");
    $finish;
  end

  // Budget of 64 cycles per row plus reset
  initial begin
    wait (tableReady);
    repeat (rows.size() * RowBudget + ResetCycles) @(posedge MAIN_SOURCE);
    watchdogFired = 1'b1;
    $display("Watchdog expired before the %0d table rows finished", rows.size());
    $display("Simulation failed");
    $fatal(1, "Timeout");
  end

  // Run stopped by a bound assertion
  final begin
    if (!runPassed && !failShown && !watchdogFired)
      $display("Simulation failed");
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/clockPkg.sv
source/diagBusPort.sv
source/runControl.sv
source/burstCounter.sv
source/rateDivider.sv
source/modeRegisters.sv
source/clockBoard.sv
tests/clockBoard_chk.sv
tests/clockBoardTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= clockBoardTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
